// File: adam_pkg.sv
`default_nettype none

package adam_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // manager side of an AXI4-Lite link
    typedef struct packed {
        logic       aw_valid;
        addr_t      aw_addr;
        logic       w_valid;
        data_t      w_data;
        logic [3:0] w_strb;
        logic       b_ready;
        logic       ar_valid;
        addr_t      ar_addr;
        logic       r_ready;
    } axil_req_t;

    // subordinate side of an AXI4-Lite link
    typedef struct packed {
        logic       aw_ready;
        logic       w_ready;
        logic       b_valid;
        logic [1:0] b_resp;
        logic       ar_ready;
        logic       r_valid;
        data_t      r_data;
        logic [1:0] r_resp;
    } axil_rsp_t;

    typedef struct packed {
        logic req;
        logic ack;
    } pause_t;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // target select on address bits 13:12, value 3 unmapped
    localparam logic [1:0] sel_syscfg = 2'd0;
    localparam logic [1:0] sel_mem    = 2'd1;
    localparam logic [1:0] sel_timer  = 2'd2;

    // syscfg register offsets
    localparam logic [7:0] off_mem_ctrl     = 8'h00;
    localparam logic [7:0] off_mem_status   = 8'h04;
    localparam logic [7:0] off_irq_en       = 8'h08;
    localparam logic [7:0] off_timer_ctrl   = 8'h10;
    localparam logic [7:0] off_timer_status = 8'h14;
    localparam logic [7:0] off_boot_addr    = 8'h20;

    // timer register offsets
    localparam logic [3:0] off_count    = 4'h0;
    localparam logic [3:0] off_compare  = 4'h4;
    localparam logic [3:0] off_tctrl    = 4'h8;
    localparam logic [3:0] off_irq_stat = 4'hc;

    // byte-strobe merge of write data into an old word
    function automatic data_t strb_merge(input data_t old, input data_t wdata,
                                         input logic [3:0] strb);
        data_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// File: adam_syscfg.sv
`default_nettype none

module adam_syscfg (
    input  logic                clk,
    input  logic                rst_n,

    input  adam_pkg::axil_req_t req,
    output adam_pkg::axil_rsp_t rsp,

    output logic                mem_rst,
    output logic                mem_pause_req,
    input  logic                mem_pause_ack,

    output logic                timer_rst,
    output logic                timer_pause_req,
    input  logic                timer_pause_ack,

    input  logic                timer_irq,
    output logic                irq,

    output adam_pkg::addr_t     boot_addr
);

    // bit 0 unit reset, bit 1 pause request
    typedef struct packed {
        logic pause;
        logic rst;
    } ctrl_t;

    ctrl_t           mem_ctrl_q;
    ctrl_t           timer_ctrl_q;
    logic            irq_en_q;
    adam_pkg::addr_t boot_addr_q;

    logic            b_valid_q;
    logic            r_valid_q;
    adam_pkg::data_t r_data_q;
    adam_pkg::data_t wr_word;
    logic            wr_acc;
    logic            rd_acc;

    // current value of a register, zero for unknown offsets
    function automatic adam_pkg::data_t reg_val(input logic [7:0] off);
        adam_pkg::data_t val;
        val = '0;
        case (off)
            adam_pkg::off_mem_ctrl:     val[1:0] = mem_ctrl_q;
            adam_pkg::off_mem_status:   val[0]   = mem_pause_ack;
            adam_pkg::off_irq_en:       val[0]   = irq_en_q;
            adam_pkg::off_timer_ctrl:   val[1:0] = timer_ctrl_q;
            adam_pkg::off_timer_status: val[0]   = timer_pause_ack;
            adam_pkg::off_boot_addr:    val      = boot_addr_q;
            default:                    val      = '0;
        endcase
        return val;
    endfunction

    assign wr_acc  = req.aw_valid && req.w_valid && !b_valid_q;
    assign rd_acc  = req.ar_valid && !r_valid_q;
    assign wr_word = adam_pkg::strb_merge(reg_val(req.aw_addr[7:0]), req.w_data, req.w_strb);

    always_comb begin
        rsp          = '0;
        rsp.aw_ready = wr_acc;
        rsp.w_ready  = wr_acc;
        rsp.b_valid  = b_valid_q;
        rsp.b_resp   = adam_pkg::resp_okay;
        rsp.ar_ready = rd_acc;
        rsp.r_valid  = r_valid_q;
        rsp.r_data   = r_data_q;
        rsp.r_resp   = adam_pkg::resp_okay;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ctrl_q   <= '0;
            timer_ctrl_q <= '0;
            irq_en_q     <= 1'b0;
            boot_addr_q  <= '0;
            b_valid_q    <= 1'b0;
            r_valid_q    <= 1'b0;
        end else begin
            if (wr_acc) begin
                // status offsets are read-only
                case (req.aw_addr[7:0])
                    adam_pkg::off_mem_ctrl:   mem_ctrl_q   <= wr_word[1:0];
                    adam_pkg::off_timer_ctrl: timer_ctrl_q <= wr_word[1:0];
                    adam_pkg::off_irq_en:     irq_en_q     <= wr_word[0];
                    adam_pkg::off_boot_addr:  boot_addr_q  <= wr_word;
                    default: ;
                endcase
            end

            if (wr_acc) begin
                b_valid_q <= 1'b1;
            end else if (req.b_ready) begin
                b_valid_q <= 1'b0;
            end

            if (rd_acc) begin
                r_valid_q <= 1'b1;
            end else if (req.r_ready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    // read data captured at acceptance
    always_ff @(posedge clk) begin
        if (rd_acc) begin
            r_data_q <= reg_val(req.ar_addr[7:0]);
        end
    end

    assign mem_rst         = mem_ctrl_q.rst;
    assign mem_pause_req   = mem_ctrl_q.pause;
    assign timer_rst       = timer_ctrl_q.rst;
    assign timer_pause_req = timer_ctrl_q.pause;

    assign irq       = timer_irq && irq_en_q;
    assign boot_addr = boot_addr_q;

endmodule

`default_nettype wire

// File: adam_fabric.sv
`default_nettype none

module adam_fabric (
    input  logic                clk,
    input  logic                rst_n,

    input  adam_pkg::axil_req_t mst_req,
    output adam_pkg::axil_rsp_t mst_rsp,

    output adam_pkg::axil_req_t syscfg_req,
    output adam_pkg::axil_req_t mem_req,
    output adam_pkg::axil_req_t timer_req,

    input  adam_pkg::axil_rsp_t syscfg_rsp,
    input  adam_pkg::axil_rsp_t mem_rsp,
    input  adam_pkg::axil_rsp_t timer_rsp
);

    logic                wr_busy_q;
    logic                rd_busy_q;
    logic [1:0]          wr_sel_q;
    logic [1:0]          rd_sel_q;
    logic [1:0]          wr_sel;
    logic [1:0]          rd_sel;

    adam_pkg::axil_req_t slv_req [3];
    adam_pkg::axil_rsp_t slv_rsp [4];
    adam_pkg::axil_rsp_t err_rsp;

    // live decode while idle, latched target while busy
    assign wr_sel = wr_busy_q ? wr_sel_q : mst_req.aw_addr[13:12];
    assign rd_sel = rd_busy_q ? rd_sel_q : mst_req.ar_addr[13:12];

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            slv_req[i]          = mst_req;
            slv_req[i].aw_valid = mst_req.aw_valid && !wr_busy_q && (wr_sel == i);
            slv_req[i].w_valid  = mst_req.w_valid && !wr_busy_q && (wr_sel == i);
            slv_req[i].b_ready  = mst_req.b_ready && wr_busy_q && (wr_sel == i);
            slv_req[i].ar_valid = mst_req.ar_valid && !rd_busy_q && (rd_sel == i);
            slv_req[i].r_ready  = mst_req.r_ready && rd_busy_q && (rd_sel == i);
        end
    end

    assign syscfg_req = slv_req[adam_pkg::sel_syscfg];
    assign mem_req    = slv_req[adam_pkg::sel_mem];
    assign timer_req  = slv_req[adam_pkg::sel_timer];

    // local subordinate for the unmapped select
    always_comb begin
        err_rsp          = '0;
        err_rsp.aw_ready = !wr_busy_q && mst_req.aw_valid && mst_req.w_valid;
        err_rsp.w_ready  = !wr_busy_q && mst_req.aw_valid && mst_req.w_valid;
        err_rsp.b_valid  = wr_busy_q;
        err_rsp.b_resp   = adam_pkg::resp_slverr;
        err_rsp.ar_ready = !rd_busy_q && mst_req.ar_valid;
        err_rsp.r_valid  = rd_busy_q;
        err_rsp.r_resp   = adam_pkg::resp_slverr;
    end

    assign slv_rsp[adam_pkg::sel_syscfg] = syscfg_rsp;
    assign slv_rsp[adam_pkg::sel_mem]    = mem_rsp;
    assign slv_rsp[adam_pkg::sel_timer]  = timer_rsp;
    assign slv_rsp[3]                    = err_rsp;

    always_comb begin
        mst_rsp          = '0;
        mst_rsp.aw_ready = slv_rsp[wr_sel].aw_ready;
        mst_rsp.w_ready  = slv_rsp[wr_sel].w_ready;
        mst_rsp.b_valid  = wr_busy_q && slv_rsp[wr_sel].b_valid;
        mst_rsp.b_resp   = slv_rsp[wr_sel].b_resp;
        mst_rsp.ar_ready = slv_rsp[rd_sel].ar_ready;
        mst_rsp.r_valid  = rd_busy_q && slv_rsp[rd_sel].r_valid;
        mst_rsp.r_data   = slv_rsp[rd_sel].r_data;
        mst_rsp.r_resp   = slv_rsp[rd_sel].r_resp;
    end

    // one outstanding transaction per direction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_busy_q <= 1'b0;
            wr_sel_q  <= '0;
            rd_busy_q <= 1'b0;
            rd_sel_q  <= '0;
        end else begin
            if (!wr_busy_q) begin
                if (mst_req.aw_valid && mst_rsp.aw_ready) begin
                    wr_busy_q <= 1'b1;
                    wr_sel_q  <= wr_sel;
                end
            end else if (mst_rsp.b_valid && mst_req.b_ready) begin
                wr_busy_q <= 1'b0;
            end

            if (!rd_busy_q) begin
                if (mst_req.ar_valid && mst_rsp.ar_ready) begin
                    rd_busy_q <= 1'b1;
                    rd_sel_q  <= rd_sel;
                end
            end else if (mst_rsp.r_valid && mst_req.r_ready) begin
                rd_busy_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: adam_mem.sv
`default_nettype none

module adam_mem #(
    parameter int no_mem_words = 256
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                unit_rst,

    input  adam_pkg::axil_req_t req,
    output adam_pkg::axil_rsp_t rsp,

    input  logic                pause_req,
    output logic                pause_ack
);

    localparam int idx_w = $clog2(no_mem_words);

    adam_pkg::data_t mem_q [no_mem_words];
    adam_pkg::data_t r_data_q;

    logic             b_valid_q;
    logic             r_valid_q;
    logic             ack_q;
    logic             busy;
    logic             done;
    logic             open;
    logic             wr_acc;
    logic             rd_acc;
    logic [idx_w-1:0] wr_idx;
    logic [idx_w-1:0] rd_idx;

    assign busy = b_valid_q || r_valid_q;
    assign done = (b_valid_q && req.b_ready) || (r_valid_q && req.r_ready);

    // no new work once a pause is requested
    assign open   = !pause_req && !ack_q && !unit_rst && !busy;
    assign wr_acc = open && req.aw_valid && req.w_valid;
    // a waiting write goes first
    assign rd_acc = open && req.ar_valid && !(req.aw_valid && req.w_valid);

    assign wr_idx = req.aw_addr[2 +: idx_w];
    assign rd_idx = req.ar_addr[2 +: idx_w];

    always_comb begin
        rsp          = '0;
        rsp.aw_ready = wr_acc;
        rsp.w_ready  = wr_acc;
        rsp.b_valid  = b_valid_q;
        rsp.b_resp   = adam_pkg::resp_okay;
        rsp.ar_ready = rd_acc;
        rsp.r_valid  = r_valid_q;
        rsp.r_data   = r_data_q;
        rsp.r_resp   = adam_pkg::resp_okay;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
            ack_q     <= 1'b0;
        end else if (unit_rst) begin
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
            ack_q     <= 1'b0;
        end else begin
            if (wr_acc) begin
                b_valid_q <= 1'b1;
            end else if (req.b_ready) begin
                b_valid_q <= 1'b0;
            end

            if (rd_acc) begin
                r_valid_q <= 1'b1;
            end else if (req.r_ready) begin
                r_valid_q <= 1'b0;
            end

            // ack once quiet, or as the pending response finishes
            ack_q <= pause_req && (!busy || done);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_acc) begin
            mem_q[wr_idx] <= adam_pkg::strb_merge(mem_q[wr_idx], req.w_data, req.w_strb);
        end
        if (rd_acc) begin
            r_data_q <= mem_q[rd_idx];
        end
    end

    assign pause_ack = ack_q;

endmodule

`default_nettype wire

// File: adam_timer.sv
`default_nettype none

module adam_timer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                unit_rst,

    input  adam_pkg::axil_req_t req,
    output adam_pkg::axil_rsp_t rsp,

    input  logic                pause_req,
    output logic                pause_ack,

    output logic                irq
);

    adam_pkg::data_t count_q;
    adam_pkg::data_t compare_q;
    adam_pkg::data_t r_data_q;
    adam_pkg::data_t wr_word;

    logic en_q;
    logic irq_q;
    logic ack_q;
    logic b_valid_q;
    logic r_valid_q;
    logic wr_acc;
    logic rd_acc;

    function automatic adam_pkg::data_t reg_val(input logic [3:0] off);
        adam_pkg::data_t val;
        val = '0;
        case (off)
            adam_pkg::off_count:    val    = count_q;
            adam_pkg::off_compare:  val    = compare_q;
            adam_pkg::off_tctrl:    val[0] = en_q;
            adam_pkg::off_irq_stat: val[0] = irq_q;
            default:                val    = '0;
        endcase
        return val;
    endfunction

    assign wr_acc  = req.aw_valid && req.w_valid && !b_valid_q && !unit_rst;
    assign rd_acc  = req.ar_valid && !r_valid_q && !unit_rst;
    assign wr_word = adam_pkg::strb_merge(reg_val(req.aw_addr[3:0]), req.w_data, req.w_strb);

    always_comb begin
        rsp          = '0;
        rsp.aw_ready = wr_acc;
        rsp.w_ready  = wr_acc;
        rsp.b_valid  = b_valid_q;
        rsp.b_resp   = adam_pkg::resp_okay;
        rsp.ar_ready = rd_acc;
        rsp.r_valid  = r_valid_q;
        rsp.r_data   = r_data_q;
        rsp.r_resp   = adam_pkg::resp_okay;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q   <= '0;
            compare_q <= '0;
            en_q      <= 1'b0;
            irq_q     <= 1'b0;
            ack_q     <= 1'b0;
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else if (unit_rst) begin
            count_q   <= '0;
            compare_q <= '0;
            en_q      <= 1'b0;
            irq_q     <= 1'b0;
            ack_q     <= 1'b0;
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            ack_q <= pause_req;

            // count frozen while the pause is acknowledged
            if (en_q && !ack_q) begin
                if (count_q == compare_q) begin
                    count_q <= '0;
                    irq_q   <= 1'b1;
                end else begin
                    count_q <= count_q + 32'd1;
                end
            end

            if (wr_acc) begin
                case (req.aw_addr[3:0])
                    adam_pkg::off_count:    count_q   <= wr_word;
                    adam_pkg::off_compare:  compare_q <= wr_word;
                    adam_pkg::off_tctrl:    en_q      <= wr_word[0];
                    // write 1 to clear
                    adam_pkg::off_irq_stat: begin
                        if (req.w_strb[0] && req.w_data[0]) begin
                            irq_q <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end

            if (wr_acc) begin
                b_valid_q <= 1'b1;
            end else if (req.b_ready) begin
                b_valid_q <= 1'b0;
            end

            if (rd_acc) begin
                r_valid_q <= 1'b1;
            end else if (req.r_ready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_acc) begin
            r_data_q <= reg_val(req.ar_addr[3:0]);
        end
    end

    assign irq       = irq_q;
    assign pause_ack = ack_q;

endmodule

`default_nettype wire

// File: adam.sv
`default_nettype none

module adam #(
    parameter int no_mem_words = 256
) (
    input  logic                clk,
    input  logic                rst_n,

    input  adam_pkg::axil_req_t axil_req,
    output adam_pkg::axil_rsp_t axil_rsp,

    output logic                irq,
    output adam_pkg::addr_t     boot_addr
);

    adam_pkg::axil_req_t syscfg_req;
    adam_pkg::axil_req_t mem_req;
    adam_pkg::axil_req_t timer_req;
    adam_pkg::axil_rsp_t syscfg_rsp;
    adam_pkg::axil_rsp_t mem_rsp;
    adam_pkg::axil_rsp_t timer_rsp;

    // req from syscfg, ack from the unit
    adam_pkg::pause_t    mem_pause;
    adam_pkg::pause_t    timer_pause;

    logic                mem_rst;
    logic                timer_rst;
    logic                timer_irq;

    adam_fabric adam_fabric (
        .clk        (clk),
        .rst_n      (rst_n),
        .mst_req    (axil_req),
        .mst_rsp    (axil_rsp),
        .syscfg_req (syscfg_req),
        .mem_req    (mem_req),
        .timer_req  (timer_req),
        .syscfg_rsp (syscfg_rsp),
        .mem_rsp    (mem_rsp),
        .timer_rsp  (timer_rsp)
    );

    adam_syscfg adam_syscfg (
        .clk             (clk),
        .rst_n           (rst_n),
        .req             (syscfg_req),
        .rsp             (syscfg_rsp),
        .mem_rst         (mem_rst),
        .mem_pause_req   (mem_pause.req),
        .mem_pause_ack   (mem_pause.ack),
        .timer_rst       (timer_rst),
        .timer_pause_req (timer_pause.req),
        .timer_pause_ack (timer_pause.ack),
        .timer_irq       (timer_irq),
        .irq             (irq),
        .boot_addr       (boot_addr)
    );

    adam_mem #(
        .no_mem_words (no_mem_words)
    ) adam_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .unit_rst  (mem_rst),
        .req       (mem_req),
        .rsp       (mem_rsp),
        .pause_req (mem_pause.req),
        .pause_ack (mem_pause.ack)
    );

    adam_timer adam_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .unit_rst  (timer_rst),
        .req       (timer_req),
        .rsp       (timer_rsp),
        .pause_req (timer_pause.req),
        .pause_ack (timer_pause.ack),
        .irq       (timer_irq)
    );

endmodule

`default_nettype wire

// File: adam_tb_tasks.svh
`ifndef ADAM_TB_TASKS_SVH
`define ADAM_TB_TASKS_SVH

// model of the memory words used by the tests, one byte-written mask per word
adam_pkg::data_t model_data [16];
logic [3:0]      model_mask [16];

// AXI4-Lite write, returns b_resp
// readies are seen just before the rising edge that takes the address
task automatic write_word(input adam_pkg::addr_t addr, input adam_pkg::data_t data,
                          input logic [3:0] strb, output logic [1:0] resp);
    @(negedge clk);
    axil_req.aw_valid = 1'b1;
    axil_req.aw_addr  = addr;
    axil_req.w_valid  = 1'b1;
    axil_req.w_data   = data;
    axil_req.w_strb   = strb;
    axil_req.b_ready  = 1'b1;
    @(posedge clk);
    while (!axil_rsp.aw_ready) begin
        @(posedge clk);
    end
    n_checks++;
    assert (axil_rsp.w_ready) else begin
        $display("write to %h: aw_ready came without w_ready", addr);
        n_errors++;
    end
    @(negedge clk);
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    while (!axil_rsp.b_valid) begin
        @(negedge clk);
    end
    resp = axil_rsp.b_resp;
    // b_ready held over the next rising edge
    @(negedge clk);
    axil_req.b_ready = 1'b0;
endtask

// AXI4-Lite read, returns r_data and r_resp
task automatic read_word(input adam_pkg::addr_t addr, output adam_pkg::data_t data,
                         output logic [1:0] resp);
    @(negedge clk);
    axil_req.ar_valid = 1'b1;
    axil_req.ar_addr  = addr;
    axil_req.r_ready  = 1'b1;
    @(posedge clk);
    while (!axil_rsp.ar_ready) begin
        @(posedge clk);
    end
    @(negedge clk);
    axil_req.ar_valid = 1'b0;
    while (!axil_rsp.r_valid) begin
        @(negedge clk);
    end
    data = axil_rsp.r_data;
    resp = axil_rsp.r_resp;
    @(negedge clk);
    axil_req.r_ready = 1'b0;
endtask

function automatic adam_pkg::data_t expand_strobes(input logic [3:0] strb);
    adam_pkg::data_t mask;
    for (int i = 0; i < 4; i++) begin
        mask[8*i +: 8] = {8{strb[i]}};
    end
    return mask;
endfunction

function automatic void clear_model();
    for (int i = 0; i < 16; i++) begin
        model_data[i] = '0;
        model_mask[i] = '0;
    end
endfunction

function automatic void merge_into_model(input int idx, input adam_pkg::data_t data,
                                         input logic [3:0] strb);
    adam_pkg::data_t mask;
    mask = expand_strobes(strb);
    model_data[idx] = (model_data[idx] & ~mask) | (data & mask);
    model_mask[idx] = model_mask[idx] | strb;
endfunction

`endif

// File: adam_tb.sv
`default_nettype none

module adam_tb;

    localparam int no_mem_words      = 256;
    localparam int cmp_value         = 20;
    localparam int poll_max          = 16;
    // transactions of all tests, irq_stat polling not included
    localparam int n_trans           = 90;
    localparam int timer_wait_cycles = poll_max * 50;
    localparam int watchdog_cycles   = n_trans * 50 + timer_wait_cycles + 4;

    logic                clk = 1'b0;
    logic                rst_n;
    adam_pkg::axil_req_t axil_req;
    adam_pkg::axil_rsp_t axil_rsp;
    logic                irq;
    adam_pkg::addr_t     boot_addr;

    int n_tests;
    int n_checks;
    int n_errors;
    int errors_before;

    `include "adam_tb_tasks.svh"

    adam #(
        .no_mem_words (no_mem_words)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .irq       (irq),
        .boot_addr (boot_addr)
    );

    always #5 clk = ~clk;

    function automatic adam_pkg::addr_t syscfg_addr(input logic [7:0] off);
        return {18'h0, adam_pkg::sel_syscfg, 4'h0, off};
    endfunction

    function automatic adam_pkg::addr_t timer_addr(input logic [3:0] off);
        return {18'h0, adam_pkg::sel_timer, 8'h0, off};
    endfunction

    function automatic adam_pkg::addr_t mem_addr(input int idx);
        return {18'h0, adam_pkg::sel_mem, idx[9:0], 2'b00};
    endfunction

    task automatic check_value(input string name, input adam_pkg::data_t exp,
                               input adam_pkg::data_t got);
        n_checks++;
        assert (got === exp) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, got);
            n_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        n_tests++;
        if (n_errors == errors_before) begin
            $display("test %-16s passed", name);
        end else begin
            $display("test %-16s FAILED, %0d mismatches", name, n_errors - errors_before);
        end
        errors_before = n_errors;
    endtask

    task automatic reset_values();
        logic [7:0]      offs [6];
        adam_pkg::data_t rdata;
        logic [1:0]      resp;
        offs = '{adam_pkg::off_mem_ctrl, adam_pkg::off_mem_status, adam_pkg::off_irq_en,
                 adam_pkg::off_timer_ctrl, adam_pkg::off_timer_status,
                 adam_pkg::off_boot_addr};
        check_value("reset boot_addr port", '0, boot_addr);
        check_value("reset irq", '0, irq);
        for (int i = 0; i < 6; i++) begin
            read_word(syscfg_addr(offs[i]), rdata, resp);
            check_value($sformatf("reset reg %h", offs[i]), '0, rdata);
            check_value("reset read resp", adam_pkg::resp_okay, resp);
        end
        write_word(syscfg_addr(adam_pkg::off_irq_en), '0, 4'hf, resp);
        check_value("reset write resp", adam_pkg::resp_okay, resp);
        finish_test("reset_values");
    endtask

    task automatic mem_readback();
        int              idx;
        adam_pkg::data_t data;
        adam_pkg::data_t mask;
        logic [3:0]      strb;
        logic [1:0]      resp;
        clear_model();
        // 16 words only, so writes overlap and merge
        for (int i = 0; i < 40; i++) begin
            idx  = $urandom_range(15, 0);
            data = $urandom;
            strb = 4'($urandom_range(15, 0));
            write_word(mem_addr(idx), data, strb, resp);
            check_value("mem write resp", adam_pkg::resp_okay, resp);
            merge_into_model(idx, data, strb);
        end
        for (int i = 0; i < 16; i++) begin
            read_word(mem_addr(i), data, resp);
            // bytes never written are left out of the compare
            mask = expand_strobes(model_mask[i]);
            check_value($sformatf("mem word %0d", i), model_data[i] & mask, data & mask);
            check_value("mem read resp", adam_pkg::resp_okay, resp);
        end
        finish_test("mem_readback");
    endtask

    task automatic unmapped_access();
        adam_pkg::data_t rdata;
        logic [1:0]      resp;
        write_word(32'h0000_3000, 32'hcafe_f00d, 4'hf, resp);
        check_value("unmapped write resp", adam_pkg::resp_slverr, resp);
        read_word(32'h0000_3004, rdata, resp);
        check_value("unmapped read resp", adam_pkg::resp_slverr, resp);
        check_value("unmapped read data", '0, rdata);
        finish_test("unmapped_access");
    endtask

    task automatic timer_interrupt();
        adam_pkg::data_t rdata;
        logic [1:0]      resp;
        int              polls;
        write_word(timer_addr(adam_pkg::off_compare), cmp_value, 4'hf, resp);
        write_word(timer_addr(adam_pkg::off_tctrl), 32'h1, 4'hf, resp);
        polls = 0;
        rdata = '0;
        while (rdata[0] !== 1'b1 && polls < poll_max) begin
            read_word(timer_addr(adam_pkg::off_irq_stat), rdata, resp);
            polls++;
        end
        assert (rdata[0] === 1'b1) else begin
            $display("timer irq_stat was still clear after %0d reads", poll_max);
            n_errors++;
        end
        check_value("irq while irq_en low", '0, irq);
        // stop counting so irq_stat is not set again
        write_word(timer_addr(adam_pkg::off_tctrl), '0, 4'hf, resp);
        write_word(syscfg_addr(adam_pkg::off_irq_en), 32'h1, 4'hf, resp);
        check_value("irq after irq_en set", 32'h1, irq);
        write_word(timer_addr(adam_pkg::off_irq_stat), 32'h1, 4'hf, resp);
        check_value("irq after clear", '0, irq);
        read_word(timer_addr(adam_pkg::off_irq_stat), rdata, resp);
        check_value("irq_stat after clear", '0, rdata);
        finish_test("timer_interrupt");
    endtask

    task automatic pause_and_reset();
        adam_pkg::data_t rdata;
        adam_pkg::data_t first;
        adam_pkg::data_t frozen;
        adam_pkg::data_t data;
        logic [1:0]      resp;
        write_word(timer_addr(adam_pkg::off_compare), 32'hffff_ffff, 4'hf, resp);
        write_word(timer_addr(adam_pkg::off_tctrl), 32'h1, 4'hf, resp);
        write_word(syscfg_addr(adam_pkg::off_mem_ctrl), 32'h2, 4'hf, resp);
        write_word(syscfg_addr(adam_pkg::off_timer_ctrl), 32'h2, 4'hf, resp);
        read_word(syscfg_addr(adam_pkg::off_mem_status), rdata, resp);
        check_value("mem pause ack", 32'h1, rdata);
        read_word(syscfg_addr(adam_pkg::off_timer_status), rdata, resp);
        check_value("timer pause ack", 32'h1, rdata);
        read_word(timer_addr(adam_pkg::off_count), first, resp);
        read_word(timer_addr(adam_pkg::off_count), frozen, resp);
        check_value("count while paused", first, frozen);
        write_word(syscfg_addr(adam_pkg::off_mem_ctrl), '0, 4'hf, resp);
        write_word(syscfg_addr(adam_pkg::off_timer_ctrl), '0, 4'hf, resp);
        data = $urandom;
        write_word(mem_addr(20), data, 4'hf, resp);
        check_value("mem write after pause", adam_pkg::resp_okay, resp);
        read_word(mem_addr(20), rdata, resp);
        check_value("mem read after pause", data, rdata);
        read_word(timer_addr(adam_pkg::off_count), rdata, resp);
        n_checks++;
        assert (rdata > frozen) else begin
            $display("[ERROR] count after release: expected above %h, actual %h", frozen, rdata);
            n_errors++;
        end
        // timer reset pulse through timer_ctrl bit 0
        write_word(syscfg_addr(adam_pkg::off_timer_ctrl), 32'h1, 4'hf, resp);
        write_word(syscfg_addr(adam_pkg::off_timer_ctrl), '0, 4'hf, resp);
        read_word(timer_addr(adam_pkg::off_count), rdata, resp);
        check_value("count after reset", '0, rdata);
        read_word(timer_addr(adam_pkg::off_compare), rdata, resp);
        check_value("compare after reset", '0, rdata);
        finish_test("pause_and_reset");
    endtask

    task automatic boot_address();
        adam_pkg::data_t value;
        adam_pkg::data_t rdata;
        logic [1:0]      resp;
        value = $urandom;
        write_word(syscfg_addr(adam_pkg::off_boot_addr), value, 4'hf, resp);
        check_value("boot_addr port", value, boot_addr);
        read_word(syscfg_addr(adam_pkg::off_boot_addr), rdata, resp);
        check_value("boot_addr readback", value, rdata);
        finish_test("boot_address");
    endtask

    initial begin
        void'($urandom(32'h46b4bf4b));
        n_tests       = 0;
        n_checks      = 0;
        n_errors      = 0;
        errors_before = 0;
        rst_n         = 1'b0;
        axil_req      = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_values();
        mem_readback();
        unmapped_access();
        timer_interrupt();
        pause_and_reset();
        boot_address();

        $display("tests %0d, checks %0d, mismatches %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // bound on the whole run, from the transaction count and the timer wait
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
adam_pkg.sv
adam_syscfg.sv
adam_fabric.sv
adam_mem.sv
adam_timer.sv
adam.sv
adam_tb.sv
